// ==== quat_dcm_pkg.sv ====
`default_nettype none

package quat_dcm_pkg;

	localparam int FX_WIDTH = 16;	// word width
	localparam int FX_FRAC  = 12;	// fraction bits, Q3.12

	typedef logic signed [FX_WIDTH-1:0] fx_t;

	localparam fx_t fx_one = fx_t'(1) <<< FX_FRAC;	// 16'h1000

	typedef struct packed {
		fx_t q0;	// scalar part
		fx_t q1;
		fx_t q2;
		fx_t q3;
	} quat_t;

	typedef struct packed {
		fx_t c11;
		fx_t c12;
		fx_t c13;
		fx_t c21;
		fx_t c22;
		fx_t c23;
		fx_t c31;
		fx_t c32;
		fx_t c33;
	} dcm_t;

	typedef enum logic {
		op_add,
		op_sub
	} addsub_op_e;

	typedef enum logic [2:0] {
		st_idle,
		st_latch,
		st_prod,	// nine products, first combines overlapped
		st_comb,	// remaining sums and differences
		st_dbl,		// x + x on all nine terms
		st_diag,	// one minus doubled sum
		st_commit,
		st_finish
	} seq_state_e;

endpackage

`default_nettype wire

// ==== fx_mult.sv ====
`default_nettype none

module fx_mult
	import quat_dcm_pkg::*;
#(
	parameter int WIDTH     = FX_WIDTH,
	parameter int FRAC_BITS = FX_FRAC
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        start,
	input  wire fx_t   a,
	input  wire fx_t   b,
	output fx_t        result,
	output logic       done
);

	localparam int PW = 2 * WIDTH;	// full product width

	logic                     busy_r;
	logic [$clog2(WIDTH)-1:0] cnt;
	logic signed [PW-1:0]     acc;
	logic signed [PW-1:0]     mcand;
	logic [WIDTH-1:0]         mplier;
	logic signed [PW-1:0]     partial;
	logic signed [PW-1:0]     acc_next;
	logic signed [PW-1:0]     prod_sh;
	logic                     ovf;

	always_comb begin
		partial = mplier[0] ? mcand : '0;
		if (cnt == WIDTH-1)
			acc_next = acc - partial;	// sign bit of b weighs negative
		else
			acc_next = acc + partial;
		prod_sh = acc_next >>> FRAC_BITS;	// floor toward minus infinity
		ovf = !((&prod_sh[PW-1:WIDTH-1]) || !(|prod_sh[PW-1:WIDTH-1]));
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy_r <= 1'b0;
			cnt    <= '0;
			done   <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start && !busy_r) begin
				busy_r <= 1'b1;
				cnt    <= '0;
			end else if (busy_r) begin
				cnt <= cnt + 1'b1;
				if (cnt == WIDTH-1) begin
					busy_r <= 1'b0;
					done   <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy_r) begin
			acc    <= '0;
			mcand  <= {{WIDTH{a[WIDTH-1]}}, a};	// sign extended
			mplier <= b;
		end else if (busy_r) begin
			acc    <= acc_next;
			mcand  <= mcand <<< 1;
			mplier <= mplier >> 1;
			if (cnt == WIDTH-1)
				result <= ovf ? {prod_sh[PW-1], {(WIDTH-1){~prod_sh[PW-1]}}}
				              : prod_sh[WIDTH-1:0];
		end
	end

	a_done_after_start: assert property (@(posedge clk) disable iff (!rst)
		done |-> $past(start, WIDTH+1));

	a_no_restart: assert property (@(posedge clk) disable iff (!rst)
		busy_r |-> !start);

endmodule

`default_nettype wire

// ==== fx_addsub.sv ====
`default_nettype none

module fx_addsub
	import quat_dcm_pkg::*;
#(
	parameter int WIDTH = FX_WIDTH
) (
	input  wire             clk,
	input  wire             rst,
	input  wire             start,
	input  wire addsub_op_e op,
	input  wire fx_t        a,
	input  wire fx_t        b,
	output fx_t             result,
	output logic            done
);

	logic [WIDTH:0] wide;	// one guard bit for overflow

	always_comb begin
		if (op == op_sub)
			wide = {a[WIDTH-1], a} - {b[WIDTH-1], b};
		else
			wide = {a[WIDTH-1], a} + {b[WIDTH-1], b};
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			done <= 1'b0;
		else
			done <= start;
	end

	always_ff @(posedge clk) begin
		if (start) begin
			if (wide[WIDTH] != wide[WIDTH-1])
				result <= {wide[WIDTH], {(WIDTH-1){~wide[WIDTH]}}};	// clamp
			else
				result <= wide[WIDTH-1:0];
		end
	end

	// a sum of two same-sign words never wraps to the other sign
	a_sum_sign: assert property (@(posedge clk) disable iff (!rst)
		start && op == op_add && a[WIDTH-1] == b[WIDTH-1]
		|=> result[WIDTH-1] == $past(a[WIDTH-1]));

endmodule

`default_nettype wire

// ==== quat_dcm_seq.sv ====
`default_nettype none

module quat_dcm_seq
	import quat_dcm_pkg::*;
#(
	parameter int FRAC_BITS = FX_FRAC
) (
	input  wire             clk,
	input  wire             rst,
	input  wire             start,
	input  wire quat_t      quat,
	output logic            busy,
	output logic            done,
	output dcm_t            dcm,
	output logic            mul_start,
	output fx_t             mul_a,
	output fx_t             mul_b,
	input  wire fx_t        mul_result,
	input  wire             mul_done,
	output logic            as_start,
	output addsub_op_e      as_op,
	output fx_t             as_a,
	output fx_t             as_b,
	input  wire fx_t        as_result,
	input  wire             as_done
);

	localparam fx_t one_c = fx_t'(1) <<< FRAC_BITS;	// one in the working format

	////////////////////////////////////////////////////////////
	// schedule tables
	////////////////////////////////////////////////////////////
	localparam logic [1:0] pair_a [0:8] = '{2'd1, 2'd2, 2'd3, 2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2};
	localparam logic [1:0] pair_b [0:8] = '{2'd1, 2'd2, 2'd3, 2'd1, 2'd2, 2'd3, 2'd2, 2'd3, 2'd3};
	// scratch slots 0..8 hold products, combine k lands in slot 9+k
	localparam logic [4:0] comb_a [0:8] = '{5'd1, 5'd0, 5'd0, 5'd6, 5'd6, 5'd7, 5'd7, 5'd8, 5'd8};
	localparam logic [4:0] comb_b [0:8] = '{5'd2, 5'd2, 5'd1, 5'd5, 5'd5, 5'd4, 5'd4, 5'd3, 5'd3};
	localparam logic [8:0] comb_sub = 9'b1_0101_0000;	// differences

	seq_state_e  state;
	seq_state_e  next_phase;
	logic [3:0]  step;
	logic [3:0]  last_step;
	logic [3:0]  comb_idx;
	logic        wait_r;
	logic        mul_pend;
	logic        as_pend;
	logic        iss_mul;
	logic        iss_as;
	logic [4:0]  sidx;
	logic [4:0]  mul_dst;
	logic [4:0]  as_dst;
	logic [4:0]  nxt_dst;
	fx_t         nxt_a;
	fx_t         nxt_b;
	addsub_op_e  nxt_op;
	quat_t       quat_r;
	fx_t         scr [0:17];

	function automatic fx_t qsel(input quat_t q, input logic [1:0] i);
		case (i)
			2'd0:    return q.q0;
			2'd1:    return q.q1;
			2'd2:    return q.q2;
			default: return q.q3;
		endcase
	endfunction

	assign busy = (state != st_idle) && (state != st_finish);
	assign done = (state == st_finish);

	// which units each step uses
	always_comb begin
		iss_mul    = 1'b0;
		iss_as     = 1'b0;
		comb_idx   = '0;
		last_step  = '0;
		next_phase = st_idle;
		case (state)
			st_prod: begin
				iss_mul    = 1'b1;
				last_step  = 4'd8;
				next_phase = st_comb;
				if (step >= 4'd7) begin
					iss_as   = 1'b1;
					comb_idx = step - 4'd4;	// cross terms of q1q2
				end else if (step >= 4'd3 && step <= 4'd5) begin
					iss_as   = 1'b1;
					comb_idx = step - 4'd3;	// diagonal sums
				end
			end
			st_comb: begin
				iss_as     = 1'b1;
				comb_idx   = step + 4'd5;
				last_step  = 4'd3;
				next_phase = st_dbl;
			end
			st_dbl: begin
				iss_as     = 1'b1;
				last_step  = 4'd8;
				next_phase = st_diag;
			end
			st_diag: begin
				iss_as     = 1'b1;
				last_step  = 4'd2;
				next_phase = st_commit;
			end
			default: ;
		endcase
	end

	// add/sub operand select
	always_comb begin
		sidx    = 5'(step) + 5'd9;
		nxt_op  = op_add;
		nxt_dst = 5'(comb_idx) + 5'd9;
		nxt_a   = scr[comb_a[comb_idx]];
		nxt_b   = scr[comb_b[comb_idx]];
		if (state == st_dbl) begin
			nxt_a   = scr[sidx];	// doubling in place
			nxt_b   = scr[sidx];
			nxt_dst = sidx;
		end else if (state == st_diag) begin
			nxt_op  = op_sub;
			nxt_a   = one_c;
			nxt_b   = scr[sidx];
			nxt_dst = sidx;
		end else if (comb_sub[comb_idx]) begin
			nxt_op = op_sub;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= st_idle;
			step      <= '0;
			wait_r    <= 1'b0;
			mul_pend  <= 1'b0;
			as_pend   <= 1'b0;
			mul_start <= 1'b0;
			as_start  <= 1'b0;
			dcm       <= '0;
		end else begin
			mul_start <= 1'b0;
			as_start  <= 1'b0;
			if (mul_done)
				mul_pend <= 1'b0;
			if (as_done)
				as_pend <= 1'b0;
			case (state)
				st_idle, st_finish: begin
					state <= start ? st_latch : st_idle;
				end
				st_latch: begin
					step   <= '0;
					wait_r <= 1'b0;
					state  <= st_prod;
				end
				st_prod, st_comb, st_dbl, st_diag: begin
					if (!wait_r) begin
						wait_r    <= 1'b1;
						mul_start <= iss_mul;
						as_start  <= iss_as;
						if (iss_mul)
							mul_pend <= 1'b1;
						if (iss_as)
							as_pend <= 1'b1;
					end else if (!mul_pend && !as_pend) begin	// all units back
						wait_r <= 1'b0;
						if (step == last_step) begin
							step  <= '0;
							state <= next_phase;
						end else begin
							step <= step + 1'b1;
						end
					end
				end
				st_commit: begin
					dcm <= '{c11: scr[9],  c12: scr[12], c13: scr[15],
					         c21: scr[13], c22: scr[10], c23: scr[16],
					         c31: scr[14], c32: scr[17], c33: scr[11]};
					state <= st_finish;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == st_idle || state == st_finish) && start)
			quat_r <= quat;
		if (!wait_r && iss_mul) begin
			mul_a   <= qsel(quat_r, pair_a[step]);
			mul_b   <= qsel(quat_r, pair_b[step]);
			mul_dst <= 5'(step);
		end
		if (!wait_r && iss_as) begin
			as_a   <= nxt_a;
			as_b   <= nxt_b;
			as_op  <= nxt_op;
			as_dst <= nxt_dst;
		end
		if (mul_done)
			scr[mul_dst] <= mul_result;
		if (as_done)
			scr[as_dst] <= as_result;
	end

	a_mul_idle: assert property (@(posedge clk) disable iff (!rst)
		mul_start |-> !$past(mul_pend));

endmodule

`default_nettype wire

// ==== quat_dcm_top.sv ====
`default_nettype none

module quat_dcm_top
	import quat_dcm_pkg::*;
#(
	parameter int WIDTH     = FX_WIDTH,
	parameter int FRAC_BITS = FX_FRAC
) (
	input  wire        clk,
	input  wire        rst,
	input  wire        start,
	input  wire quat_t quat,
	output logic       busy,
	output logic       done,
	output dcm_t       dcm
);

	////////////////////////////////////////////////////////////
	// sequencer to arithmetic units
	////////////////////////////////////////////////////////////
	logic       mul_start;
	fx_t        mul_a;
	fx_t        mul_b;
	fx_t        mul_result;
	logic       mul_done;
	logic       as_start;
	addsub_op_e as_op;
	fx_t        as_a;
	fx_t        as_b;
	fx_t        as_result;
	logic       as_done;

	quat_dcm_seq #(
		.FRAC_BITS (FRAC_BITS)
	) u_seq (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.quat       (quat),
		.busy       (busy),
		.done       (done),
		.dcm        (dcm),
		.mul_start  (mul_start),
		.mul_a      (mul_a),
		.mul_b      (mul_b),
		.mul_result (mul_result),
		.mul_done   (mul_done),
		.as_start   (as_start),
		.as_op      (as_op),
		.as_a       (as_a),
		.as_b       (as_b),
		.as_result  (as_result),
		.as_done    (as_done)
	);

	fx_mult #(
		.WIDTH     (WIDTH),
		.FRAC_BITS (FRAC_BITS)
	) u_mult (
		.clk    (clk),
		.rst    (rst),
		.start  (mul_start),
		.a      (mul_a),
		.b      (mul_b),
		.result (mul_result),
		.done   (mul_done)
	);

	fx_addsub #(
		.WIDTH (WIDTH)
	) u_addsub (
		.clk    (clk),
		.rst    (rst),
		.start  (as_start),
		.op     (as_op),
		.a      (as_a),
		.b      (as_b),
		.result (as_result),
		.done   (as_done)
	);

endmodule

`default_nettype wire

// ==== tb_quat_dcm.sv ====
`default_nettype none

module tb_quat_dcm
	import quat_dcm_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIDTH      = FX_WIDTH;
	localparam int RUN_CYCLES = 40 * (WIDTH + 4);	// bound on a single run
	localparam int W          = $bits(fx_t);
	localparam logic [31:0] SEED = 32'h4b510b17;

	logic  clk;
	logic  rst;
	logic  start;
	quat_t quat;
	logic  busy;
	logic  done;
	dcm_t  dcm;

	quat_t vec_quat [$];
	dcm_t  vec_dcm [$];
	dcm_t  held_dcm;	// matrix dcm must show until the next done
	logic  loaded;

	quat_dcm_top UUT (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.quat  (quat),
		.busy  (busy),
		.done  (done),
		.dcm   (dcm)
	);

	always #50 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	////////////////////////////////////////////////////////////
	// pattern file
	////////////////////////////////////////////////////////////
	task automatic load_patterns();
		int               fd;
		int               n;
		logic [8*256-1:0] line_buf;
		fx_t              w [13];
		fd = $fopen("quat_dcm_patterns.txt", "r");
		assert (fd != 0) else abort_run("could not open quat_dcm_patterns.txt for reading");
		while ($fgets(line_buf, fd) > 0) begin
			n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
				w[0], w[1], w[2], w[3], w[4], w[5], w[6],
				w[7], w[8], w[9], w[10], w[11], w[12]);
			if (n == 13) begin	// comment lines give no words
				vec_quat.push_back({w[0], w[1], w[2], w[3]});
				vec_dcm.push_back({w[4], w[5], w[6], w[7], w[8], w[9], w[10], w[11], w[12]});
			end
		end
		$fclose(fd);
		assert (vec_quat.size() >= 3) else
			abort_run("the pattern file holds fewer than three vectors");
	endtask

	task automatic check_matrix(input dcm_t exp, input string tag);
		string names [9] = '{"c11", "c12", "c13", "c21", "c22", "c23", "c31", "c32", "c33"};
		fx_t   got_w;
		fx_t   exp_w;
		int    i;
		for (i = 0; i < 9; i++) begin
			got_w = dcm[(8 - i) * W +: W];	// c11 sits in the top word
			exp_w = exp[(8 - i) * W +: W];
			assert (got_w == exp_w) else
				abort_run($sformatf("FAILED at %0d ns: %s, %s is %h, expected %h",
					$time, tag, names[i], got_w, exp_w));
		end
	endtask

	////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			assert (!busy && !done) else
				abort_run($sformatf("FAILED at %0d ns: busy=%b done=%b while idle",
					$time, busy, done));
			check_matrix(held_dcm, "idle hold");
		end
	endtask

	task automatic pulse_start(input quat_t q);
		@(posedge clk);
		start <= 1'b1;
		quat  <= q;
		@(negedge clk);
		assert (!done) else
			abort_run($sformatf("FAILED at %0d ns: done high while start is driven", $time));
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic await_done(input dcm_t exp, input string tag);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!done) begin
			assert (busy) else
				abort_run($sformatf("FAILED at %0d ns: %s, busy low before done", $time, tag));
			check_matrix(held_dcm, {tag, " hold"});	// old matrix stays until done
			cycles++;
			assert (cycles < RUN_CYCLES) else
				abort_run($sformatf("timeout: %s gave no done within %0d cycles",
					tag, RUN_CYCLES));
			@(negedge clk);
		end
		assert (!busy) else
			abort_run($sformatf("FAILED at %0d ns: %s, busy high with done", $time, tag));
		check_matrix(exp, tag);
		held_dcm = exp;
	endtask

	task automatic run_quat(input quat_t q, input dcm_t exp, input string tag);
		pulse_start(q);
		await_done(exp, tag);
	endtask

	// start stays high, so each next run is taken in the done cycle
	task automatic run_chain();
		int i;
		@(posedge clk);
		start <= 1'b1;
		quat  <= vec_quat[0];
		for (i = 0; i < vec_quat.size(); i++) begin
			@(posedge clk);	// run i accepted on this edge
			if (i + 1 < vec_quat.size())
				quat <= vec_quat[i + 1];
			else
				start <= 1'b0;
			await_done(vec_dcm[i], $sformatf("back to back %0d", i));
		end
	endtask

	initial begin
		int limit;
		wait (loaded);
		limit = (2 * vec_quat.size() + 2) * RUN_CYCLES + 100;
		repeat (limit) @(posedge clk);
		abort_run($sformatf("timeout: the test did not end within %0d clock cycles", limit));
	end

	initial begin
		quat_t ident_q;
		dcm_t  ident_m;
		int    i;
		clk      = 1'b0;
		rst      = 1'b0;
		start    = 1'b0;
		quat     = '0;
		held_dcm = '0;
		loaded   = 1'b0;
		void'($urandom(SEED));
		load_patterns();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b1;

		idle_cycles(2);	// cleared outputs after reset

		// identity rotation, one on the diagonal
		ident_q     = '0;
		ident_q.q0  = fx_one;
		ident_m     = '0;
		ident_m.c11 = fx_one;
		ident_m.c22 = fx_one;
		ident_m.c33 = fx_one;
		run_quat(ident_q, ident_m, "identity");

		for (i = 0; i < vec_quat.size(); i++) begin
			idle_cycles($urandom % 4);
			run_quat(vec_quat[i], vec_dcm[i], $sformatf("vector %0d", i));
		end

		// second start lands while busy and must be dropped
		idle_cycles(1);
		pulse_start(vec_quat[1]);
		pulse_start(vec_quat[2]);
		await_done(vec_dcm[1], "start while busy");
		idle_cycles(4);

		run_chain();
		idle_cycles(2);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== quat_dcm_patterns.txt ====
# columns: q0 q1 q2 q3 then c11 c12 c13 c21 c22 c23 c31 c32 c33
# every word is Q3.12 fixed point in hex
# 90 degree rotations about x, y and z
0b50 0b50 0000 0000 1000 0000 0000 0000 0002 0ffe 0000 f002 0002
0b50 0000 0b50 0000 0002 0000 f002 0000 1000 0000 0ffe 0000 0002
0b50 0000 0000 0b50 0002 0ffe 0000 f002 0002 0000 0000 0000 1000
# negative components
f800 0800 f800 0800 0000 f000 0000 0000 0000 f000 1000 0000 0000
# general unit quaternion, products round toward minus infinity
0ccd 0666 0666 fccd 099c fffe f334 0a3e 099c 07ac 07ac f334 05c4
# all components 1.5, doubled terms saturate
1800 1800 1800 1800 9001 7fff 0000 0000 9001 7fff 7fff 0000 9001

// ==== quat_dcm.f ====
quat_dcm_pkg.sv
fx_mult.sv
fx_addsub.sv
quat_dcm_seq.sv
quat_dcm_top.sv
tb_quat_dcm.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_quat_dcm
FILELIST  ?= quat_dcm.f
OBJ_DIR   ?= obj_dir
PATTERNS  ?= quat_dcm_patterns.txt
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(PATTERNS)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
